//--- Makefile
SIM      = verilator
TOP      = tb_cl_hello_world
FILELIST = sources.f
VFLAGS   = --binary --timing --assert
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

# Pass only if the log holds the pass line
sim:
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- dv/cl_hello_world_props.sv
// Handshake properties for the hello-world endpoint
// Response hold under back-pressure, b/r exclusivity and quiet
// bridge pops while reset is applied

`timescale 1ns/100ps

module cl_hello_world_props
   import axi_pkg::*;
#(
   parameter int BUS_WIDTH = 512
) (
   input logic                 clk,
   input logic                 sync_rst_n,
   input axi_b_rsp_t           b,
   input logic                 b_valid,
   input logic                 b_ready,
   input axi_r_rsp_t           r,
   input logic [BUS_WIDTH-1:0] r_data,
   input logic                 r_valid,
   input logic                 r_ready,
   input logic                 aw_q_ready,
   input logic                 w_q_ready,
   input logic                 ar_q_ready
);

   // Responses hold until accepted
   b_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
      b_valid && !b_ready |=> b_valid && $stable(b))
      else $error("b_valid dropped or b changed before b_ready");

   r_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
      r_valid && !r_ready |=> r_valid && $stable(r) && $stable(r_data))
      else $error("r_valid dropped or r changed before r_ready");

   // One access in flight, so never both
   b_r_excl: assert property (@(posedge clk) disable iff (!sync_rst_n)
      !(b_valid && r_valid))
      else $error("b_valid and r_valid high together");

   // Bridge pops stay low while in reset
   rst_quiet: assert property (@(posedge clk)
      !sync_rst_n |=> !aw_q_ready && !w_q_ready && !ar_q_ready)
      else $error("request channel popped during reset");

endmodule

bind cl_hello_world cl_hello_world_props #(.BUS_WIDTH(BUS_WIDTH)) props (
   .clk        (clk),
   .sync_rst_n (sync_rst_n),
   .b          (b),
   .b_valid    (b_valid),
   .b_ready    (b_ready),
   .r          (r),
   .r_data     (r_data),
   .r_valid    (r_valid),
   .r_ready    (r_ready),
   .aw_q_ready (aw_q_ready),
   .w_q_ready  (w_q_ready),
   .ar_q_ready (ar_q_ready)
);

//--- dv/tb_cl_hello_world.sv
// Testbench for the hello-world PCIe slave endpoint
// Random single-beat AXI writes and reads under random b/r stalls,
// checked in order against a model of the hello register

`timescale 1ns/100ps

module tb_cl_hello_world
   import axi_pkg::*;
();

   localparam int          BUS_WIDTH    = 512;
   localparam int          LANES        = BUS_WIDTH / 32;
   localparam int          RAND_GROUPS  = 150;
   localparam int          TXN_LIMIT    = 6 + 3 * RAND_GROUPS;
   localparam int          CYCLE_BUDGET = 16 + 200 * TXN_LIMIT;
   localparam logic [31:0] SEED         = 32'h6a31_6039;

   // Expected read response and the b count that must precede it
   typedef struct packed {
      axi_id_t              id;
      logic [BUS_WIDTH-1:0] data;
      logic [31:0]          b_before;
   } rd_exp_t;

   logic                 clk;
   logic                 sync_rst_n;
   axi_addr_req_t        aw;
   logic                 aw_valid;
   logic                 aw_ready;
   logic [BUS_WIDTH-1:0] w_data;
   logic                 w_valid;
   logic                 w_ready;
   axi_addr_req_t        ar;
   logic                 ar_valid;
   logic                 ar_ready;
   axi_b_rsp_t           b;
   logic                 b_valid;
   logic                 b_ready;
   axi_r_rsp_t           r;
   logic [BUS_WIDTH-1:0] r_data;
   logic                 r_valid;
   logic                 r_ready;

   integer      seed;
   integer      stall_seed;
   logic [31:0] stall_rnd;
   logic [31:0] hello_model;
   int unsigned b_issued;
   int unsigned b_seen;
   axi_id_t     b_exp_q[$];
   rd_exp_t     r_exp_q[$];

   cl_hello_world #(.BUS_WIDTH(BUS_WIDTH)) UUT (.*);

   always #10 clk = ~clk;

   // --------------------
   // Failure reporting
   // --------------------
   task automatic abort_run();
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic report_failure(string why);
      $display("error: %0t %s", $time, why);
      abort_run();
   endtask

   task automatic value_error(string sig, logic [BUS_WIDTH-1:0] got,
                              logic [BUS_WIDTH-1:0] want);
      $display("error: %0t %s got %0h expected %0h", $time, sig, got, want);
      abort_run();
   endtask

   // --------------------
   // Stimulus helpers
   // --------------------
   function automatic logic [31:0] byte_swap(logic [31:0] v);
      return {v[7:0], v[15:8], v[23:16], v[31:24]};
   endfunction

   function automatic axi_addr_req_t make_req(axi_id_t id, logic [7:0] offset);
      return '{id: id, addr: {56'd0, offset}};
   endfunction

   // Three in four accesses hit offset 0x00, the rest any offset and lane
   function automatic axi_addr_req_t draw_request();
      logic [31:0]   rnd_hi;
      logic [31:0]   rnd_lo;
      logic [31:0]   rnd_off;
      axi_addr_req_t req;
      rnd_hi   = $random(seed);
      rnd_lo   = $random(seed);
      rnd_off  = $random(seed);
      req.id   = rnd_off[20:16];
      req.addr = {rnd_hi, rnd_lo[31:8], 8'h00};
      if (rnd_off[9:8] == 2'b00)
         req.addr[7:0] = rnd_off[7:0];
      return req;
   endfunction

   function automatic logic [BUS_WIDTH-1:0] draw_data();
      logic [BUS_WIDTH-1:0] data;
      for (int i = 0; i < LANES; i++)
         data[32*i +: 32] = $random(seed);
      return data;
   endfunction

   // Predict, then present aw/w and ar together and hold until each transfers
   task automatic issue(logic do_wr, logic do_rd, axi_addr_req_t wr_req,
                        logic [BUS_WIDTH-1:0] wr_data, axi_addr_req_t rd_req);
      logic       aw_hs;
      logic       w_hs;
      logic       ar_hs;
      logic [3:0] lane;
      rd_exp_t    want;
      // Write is served first
      if (do_wr)
      begin
         lane = wr_req.addr[5:2];
         if (wr_req.addr[7:0] == 8'h00)
            hello_model = wr_data[32*lane +: 32];
         b_exp_q.push_back(wr_req.id);
         b_issued++;
      end
      if (do_rd)
      begin
         lane      = rd_req.addr[5:2];
         want.id   = rd_req.id;
         want.data = '0;
         if (rd_req.addr[7:0] == 8'h00)
            want.data[32*lane +: 32] = byte_swap(hello_model);
         else
            want.data[32*lane +: 32] = 32'hffff_ffff;
         want.b_before = b_issued;
         r_exp_q.push_back(want);
      end
      aw       = wr_req;
      w_data   = wr_data;
      ar       = rd_req;
      aw_valid = do_wr;
      w_valid  = do_wr;
      ar_valid = do_rd;
      while (aw_valid || w_valid || ar_valid)
      begin
         @(negedge clk);
         aw_hs = aw_valid && aw_ready;
         w_hs  = w_valid && w_ready;
         ar_hs = ar_valid && ar_ready;
         @(posedge clk);
         #1;
         if (aw_hs)
            aw_valid = 1'b0;
         if (w_hs)
            w_valid = 1'b0;
         if (ar_hs)
            ar_valid = 1'b0;
      end
   endtask

   task automatic drain();
      while (b_exp_q.size() != 0 || r_exp_q.size() != 0)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   // --------------------
   // Response checks
   // --------------------
   task automatic compare_b();
      axi_id_t want_id;
      assert (b_exp_q.size() != 0)
         else report_failure("write response with no write outstanding");
      want_id = b_exp_q.pop_front();
      assert (b.id == want_id)
         else value_error("b.id", BUS_WIDTH'(b.id), BUS_WIDTH'(want_id));
      assert (b.resp == AXI_RESP_OKAY)
         else value_error("b.resp", BUS_WIDTH'(b.resp), BUS_WIDTH'(AXI_RESP_OKAY));
      b_seen++;
   endtask

   task automatic compare_r();
      rd_exp_t want;
      assert (r_exp_q.size() != 0)
         else report_failure("read response with no read outstanding");
      want = r_exp_q.pop_front();
      assert (b_seen >= want.b_before)
         else report_failure("read response arrived before an earlier write response");
      assert (r.id == want.id)
         else value_error("r.id", BUS_WIDTH'(r.id), BUS_WIDTH'(want.id));
      assert (r.resp == AXI_RESP_OKAY)
         else value_error("r.resp", BUS_WIDTH'(r.resp), BUS_WIDTH'(AXI_RESP_OKAY));
      assert (r.last)
         else value_error("r.last", BUS_WIDTH'(r.last), BUS_WIDTH'(1'b1));
      assert (r_data == want.data)
         else value_error("r_data", r_data, want.data);
   endtask

   // Transfers complete on the following rising edge
   always @(negedge clk)
   begin
      if (sync_rst_n && b_valid && b_ready)
         compare_b();
      if (sync_rst_n && r_valid && r_ready)
         compare_r();
   end

   // Random response back-pressure, on a stream of its own
   initial
   begin
      stall_seed = SEED ^ 32'h0000_ffff;
      b_ready    = 1'b0;
      r_ready    = 1'b0;
      forever
      begin
         @(posedge clk);
         #1;
         stall_rnd = $random(stall_seed);
         b_ready   = (stall_rnd[1:0] != 2'b00);
         r_ready   = (stall_rnd[3:2] != 2'b00);
      end
   end

   initial
   begin
      repeat (CYCLE_BUDGET) @(posedge clk);
      report_failure("watchdog expired, responses stopped arriving");
   end

   // --------------------
   // Main sequence
   // --------------------
   initial
   begin
      logic [31:0] grp_rnd;
      int          count;
      seed        = SEED;
      hello_model = '0;
      b_issued    = 0;
      b_seen      = 0;
      clk         = 1'b0;
      sync_rst_n  = 1'b0;
      aw          = '0;
      aw_valid    = 1'b0;
      w_data      = '0;
      w_valid     = 1'b0;
      ar          = '0;
      ar_valid    = 1'b0;
      repeat (16) @(posedge clk);
      #1;
      sync_rst_n = 1'b1;

      // Reset value, hello write, then an ignored unmapped write
      issue(1'b0, 1'b1, '0, '0, make_req(5'd1, 8'h00));
      drain();
      issue(1'b1, 1'b0, make_req(5'd2, 8'h00), draw_data(), '0);
      issue(1'b0, 1'b1, '0, '0, make_req(5'd3, 8'h00));
      drain();
      issue(1'b1, 1'b0, make_req(5'd4, 8'h48), draw_data(), '0);
      issue(1'b0, 1'b1, '0, '0, make_req(5'd5, 8'h00));
      issue(1'b0, 1'b1, '0, '0, make_req(5'd6, 8'h3c));
      drain();

      // Write bursts, read bursts and simultaneous pairs
      for (int g = 0; g < RAND_GROUPS; g++)
      begin
         grp_rnd = $random(seed);
         count   = (grp_rnd[1:0] == 2'b00) ? 1 : int'(grp_rnd[1:0]);
         if (grp_rnd[3:2] == 2'b00)
            issue(1'b1, 1'b1, draw_request(), draw_data(), draw_request());
         else
            for (int n = 0; n < count; n++)
               if (grp_rnd[4])
                  issue(1'b1, 1'b0, draw_request(), draw_data(), '0);
               else
                  issue(1'b0, 1'b1, '0, '0, draw_request());
         drain();
      end

      if (b_exp_q.size() == 0 && r_exp_q.size() == 0)
      begin
         $display("sim passed");
         $finish;
      end
      else
         report_failure("responses still outstanding at the end of the run");
   end

endmodule

//--- hw/axi_pkg.sv
// Host AXI bus types
// IDs, addresses, response codes and the single-beat channel
// structs shared by the top level and the bridge

package axi_pkg;

   // Widths that carry meaning on the host bus
   typedef logic [4:0]  axi_id_t;
   typedef logic [63:0] axi_addr_t;
   typedef logic [1:0]  axi_resp_t;

   localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

   // Request address, common to aw and ar
   typedef struct packed {
      axi_id_t   id;
      axi_addr_t addr;
   } axi_addr_req_t;

   // Write response
   typedef struct packed {
      axi_id_t   id;
      axi_resp_t resp;
   } axi_b_rsp_t;

   // Read response sideband, data travels beside it
   typedef struct packed {
      axi_id_t   id;
      axi_resp_t resp;
      logic      last;
   } axi_r_rsp_t;

endpackage

//--- hw/axi_skid_buffer.sv
// Two-entry register slice for one valid/ready channel
// Keeps full throughput under back-pressure; the second entry
// only fills when the output register is held

`timescale 1ns/100ps

module axi_skid_buffer #(
   parameter int PAYLOAD_WIDTH = 32
) (
   input  logic                     clk,
   input  logic                     sync_rst_n,
   input  logic [PAYLOAD_WIDTH-1:0] in_data,
   input  logic                     in_valid,
   output logic                     in_ready,
   output logic [PAYLOAD_WIDTH-1:0] out_data,
   output logic                     out_valid,
   input  logic                     out_ready
);

   logic                     out_valid_q;
   logic [PAYLOAD_WIDTH-1:0] out_data_q;
   logic                     skid_valid_q;
   logic [PAYLOAD_WIDTH-1:0] skid_data_q;

   logic push;
   logic out_free;

   // Skid entry is only used when the output entry is full
   assign in_ready = ~skid_valid_q;
   assign push     = in_valid & in_ready;
   assign out_free = ~out_valid_q | out_ready;

   assign out_valid = out_valid_q;
   assign out_data  = out_data_q;

   // Occupancy
   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         out_valid_q  <= 1'b0;
         skid_valid_q <= 1'b0;
      end
      else if (out_free)
      begin
         out_valid_q  <= skid_valid_q | push;
         skid_valid_q <= 1'b0;
      end
      else if (push)
      begin
         skid_valid_q <= 1'b1;
      end

   // Payload, oldest entry always at the output
   always_ff @(posedge clk)
      if (out_free)
      begin
         if (skid_valid_q)
            out_data_q <= skid_data_q;
         else if (push)
            out_data_q <= in_data;
      end
      else if (push)
      begin
         skid_data_q <= in_data;
      end

endmodule

//--- hw/cl_hello_world.sv
// Hello-world PCIe slave endpoint
// Host AXI requests pass through per-channel skid buffers into the
// access bridge, which drives the hello-world register block

`timescale 1ns/100ps

module cl_hello_world
   import axi_pkg::*;
   import hello_pkg::*;
#(
   parameter int BUS_WIDTH = 512
) (
   input  logic                 clk,
   input  logic                 sync_rst_n,
   input  axi_addr_req_t        aw,
   input  logic                 aw_valid,
   output logic                 aw_ready,
   input  logic [BUS_WIDTH-1:0] w_data,
   input  logic                 w_valid,
   output logic                 w_ready,
   input  axi_addr_req_t        ar,
   input  logic                 ar_valid,
   output logic                 ar_ready,
   output axi_b_rsp_t           b,
   output logic                 b_valid,
   input  logic                 b_ready,
   output axi_r_rsp_t           r,
   output logic [BUS_WIDTH-1:0] r_data,
   output logic                 r_valid,
   input  logic                 r_ready
);

   // Bridge side of the request channels
   axi_addr_req_t        aw_q, ar_q;
   logic                 aw_q_valid, aw_q_ready;
   logic [BUS_WIDTH-1:0] w_q_data;
   logic                 w_q_valid, w_q_ready;
   logic                 ar_q_valid, ar_q_ready;

   cfg_req_t  cfg_req;
   logic      cfg_ack;
   reg_data_t cfg_rdata;

   // --------------------
   // Request slices
   // --------------------
   axi_skid_buffer #(.PAYLOAD_WIDTH($bits(axi_addr_req_t))) aw_slice (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .in_data    (aw),
      .in_valid   (aw_valid),
      .in_ready   (aw_ready),
      .out_data   (aw_q),
      .out_valid  (aw_q_valid),
      .out_ready  (aw_q_ready)
   );

   axi_skid_buffer #(.PAYLOAD_WIDTH(BUS_WIDTH)) w_slice (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .in_data    (w_data),
      .in_valid   (w_valid),
      .in_ready   (w_ready),
      .out_data   (w_q_data),
      .out_valid  (w_q_valid),
      .out_ready  (w_q_ready)
   );

   axi_skid_buffer #(.PAYLOAD_WIDTH($bits(axi_addr_req_t))) ar_slice (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .in_data    (ar),
      .in_valid   (ar_valid),
      .in_ready   (ar_ready),
      .out_data   (ar_q),
      .out_valid  (ar_q_valid),
      .out_ready  (ar_q_ready)
   );

   // --------------------
   // Bridge and registers
   // --------------------
   pcis_slave_bridge #(.BUS_WIDTH(BUS_WIDTH)) bridge (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .aw         (aw_q),
      .aw_valid   (aw_q_valid),
      .aw_ready   (aw_q_ready),
      .w_data     (w_q_data),
      .w_valid    (w_q_valid),
      .w_ready    (w_q_ready),
      .ar         (ar_q),
      .ar_valid   (ar_q_valid),
      .ar_ready   (ar_q_ready),
      .b          (b),
      .b_valid    (b_valid),
      .b_ready    (b_ready),
      .r          (r),
      .r_data     (r_data),
      .r_valid    (r_valid),
      .r_ready    (r_ready),
      .cfg_req    (cfg_req),
      .cfg_ack    (cfg_ack),
      .cfg_rdata  (cfg_rdata)
   );

   hello_regs regs (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .cfg_req    (cfg_req),
      .cfg_ack    (cfg_ack),
      .cfg_rdata  (cfg_rdata)
   );

endmodule

//--- hw/hello_pkg.sv
// Register map and bridge types
// Offsets, readback constants, the bridge FSM encoding and the
// pulse request sent from the bridge to the register block

package hello_pkg;

   typedef logic [7:0]  reg_addr_t;
   typedef logic [31:0] reg_data_t;

   // Lane select bits above the word offset, 16 lanes on a 512-bit bus
   localparam int LANE_BITS = 4;

   localparam reg_addr_t HELLO_OFFSET   = 8'h00;
   localparam reg_data_t UNMAPPED_RDATA = 32'hffff_ffff;

   // One-cycle request toward the register block
   typedef struct packed {
      logic      wr;
      logic      rd;
      reg_addr_t addr;
      reg_data_t wdata;
   } cfg_req_t;

   typedef enum logic [1:0] {
      SLV_IDLE    = 2'd0,
      SLV_WR_ADDR = 2'd1,
      SLV_CYC     = 2'd2,
      SLV_RESP    = 2'd3
   } slv_state_t;

endpackage

//--- hw/hello_regs.sv
// Hello-world register block
// Stretches the request pulse, acknowledges two cycles later and
// serves one register at offset 0x00 that reads back byte-reversed

`timescale 1ns/100ps

module hello_regs
   import hello_pkg::*;
(
   input  logic      clk,
   input  logic      sync_rst_n,
   input  cfg_req_t  cfg_req,
   output logic      cfg_ack,
   output reg_data_t cfg_rdata
);

   logic      wr_stretch;
   logic      rd_stretch;
   reg_addr_t addr_q;
   reg_data_t wdata_q;
   reg_data_t hello_q;

   // Hold the request until acknowledged
   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         wr_stretch <= 1'b0;
         rd_stretch <= 1'b0;
         cfg_ack    <= 1'b0;
      end
      else
      begin
         wr_stretch <= cfg_req.wr || (wr_stretch && !cfg_ack);
         rd_stretch <= cfg_req.rd || (rd_stretch && !cfg_ack);
         cfg_ack    <= (wr_stretch || rd_stretch) && !cfg_ack;
      end

   always_ff @(posedge clk)
      if (cfg_req.wr || cfg_req.rd)
      begin
         addr_q  <= cfg_req.addr;
         wdata_q <= cfg_req.wdata;
      end

   // --------------------
   // Hello register
   // --------------------
   always_ff @(posedge clk)
      if (!sync_rst_n)
         hello_q <= '0;
      else if (wr_stretch && addr_q == HELLO_OFFSET)
         hello_q <= wdata_q;

   // Readback lands together with the acknowledge
   always_ff @(posedge clk)
      if (addr_q == HELLO_OFFSET)
         cfg_rdata <= {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};
      else
         cfg_rdata <= UNMAPPED_RDATA;

endmodule

//--- hw/pcis_slave_bridge.sv
// PCIe slave access bridge
// Serves one single-beat AXI access at a time with writes first,
// picks the 32-bit lane from addr[5:2] and issues a one-cycle
// request to the register block, then returns b or r

`timescale 1ns/100ps

module pcis_slave_bridge
   import axi_pkg::*;
   import hello_pkg::*;
#(
   parameter int BUS_WIDTH = 512
) (
   input  logic                 clk,
   input  logic                 sync_rst_n,
   input  axi_addr_req_t        aw,
   input  logic                 aw_valid,
   output logic                 aw_ready,
   input  logic [BUS_WIDTH-1:0] w_data,
   input  logic                 w_valid,
   output logic                 w_ready,
   input  axi_addr_req_t        ar,
   input  logic                 ar_valid,
   output logic                 ar_ready,
   output axi_b_rsp_t           b,
   output logic                 b_valid,
   input  logic                 b_ready,
   output axi_r_rsp_t           r,
   output logic [BUS_WIDTH-1:0] r_data,
   output logic                 r_valid,
   input  logic                 r_ready,
   output cfg_req_t             cfg_req,
   input  logic                 cfg_ack,
   input  reg_data_t            cfg_rdata
);

   slv_state_t state, state_nxt;

   logic      cyc_wr;
   logic      did_req;
   logic      issue;
   axi_addr_t wr_addr_q, rd_addr_q;
   axi_id_t   wr_id_q, rd_id_q;
   axi_addr_t mx_addr;
   logic      rsp_ready;
   logic      req_valid;
   reg_data_t rdata_q;

   logic [LANE_BITS-1:0] wr_lane, rd_lane;
   logic [BUS_WIDTH-1:0] w_lane_data;

   logic      req_wr_q, req_rd_q;
   reg_addr_t req_addr_q;
   reg_data_t req_wdata_q;

   assign mx_addr   = cyc_wr ? wr_addr_q : rd_addr_q;
   assign rsp_ready = cyc_wr ? b_ready : r_ready;
   // Reads need no data beat
   assign req_valid = cyc_wr ? w_valid : 1'b1;

   assign wr_lane     = wr_addr_q[2 +: LANE_BITS];
   assign rd_lane     = rd_addr_q[2 +: LANE_BITS];
   assign w_lane_data = w_data >> (32 * wr_lane);

   // Latch both sides; the loser is latched again when it is served
   always_ff @(posedge clk)
      if (state == SLV_IDLE && (aw_valid || ar_valid))
      begin
         wr_addr_q <= aw.addr;
         wr_id_q   <= aw.id;
         rd_addr_q <= ar.addr;
         rd_id_q   <= ar.id;
      end

   // --------------------
   // Access FSM
   // --------------------
   always_comb
   begin
      state_nxt = state;
      unique case (state)
         SLV_IDLE:
            if (aw_valid)
               state_nxt = SLV_WR_ADDR;
            else if (ar_valid)
               state_nxt = SLV_CYC;
         SLV_WR_ADDR:
            state_nxt = SLV_CYC;
         SLV_CYC:
            if (cfg_ack)
               state_nxt = SLV_RESP;
         SLV_RESP:
            if (rsp_ready)
               state_nxt = SLV_IDLE;
         default:
            state_nxt = SLV_IDLE;
      endcase
   end

   // Request issues once per access
   assign issue = (state == SLV_CYC) && req_valid && !did_req;

   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         state    <= SLV_IDLE;
         cyc_wr   <= 1'b0;
         did_req  <= 1'b0;
         req_wr_q <= 1'b0;
         req_rd_q <= 1'b0;
         aw_ready <= 1'b0;
         w_ready  <= 1'b0;
         ar_ready <= 1'b0;
      end
      else
      begin
         state <= state_nxt;
         if (state == SLV_IDLE)
            cyc_wr <= aw_valid;
         did_req  <= (state != SLV_IDLE) && (did_req || issue);
         req_wr_q <= issue && cyc_wr;
         req_rd_q <= issue && !cyc_wr;
         // Pops, one cycle each
         aw_ready <= (state_nxt == SLV_WR_ADDR);
         w_ready  <= (state == SLV_CYC) && (state_nxt != SLV_CYC) && cyc_wr;
         ar_ready <= (state == SLV_CYC) && (state_nxt != SLV_CYC) && !cyc_wr;
      end

   // Request payload, taken in the same cycle as the pulse
   always_ff @(posedge clk)
   begin
      req_addr_q  <= mx_addr[7:0];
      req_wdata_q <= w_lane_data[31:0];
   end

   assign cfg_req = '{wr: req_wr_q, rd: req_rd_q, addr: req_addr_q, wdata: req_wdata_q};

   always_ff @(posedge clk)
      if (cfg_ack)
         rdata_q <= cfg_rdata;

   // --------------------
   // Responses
   // --------------------
   assign b       = '{id: wr_id_q, resp: AXI_RESP_OKAY};
   assign b_valid = (state == SLV_RESP) && cyc_wr;

   // Single beat, so last is always set
   assign r       = '{id: rd_id_q, resp: AXI_RESP_OKAY, last: 1'b1};
   assign r_data  = BUS_WIDTH'(rdata_q) << (32 * rd_lane);
   assign r_valid = (state == SLV_RESP) && !cyc_wr;

endmodule

//--- sources.f
hw/axi_pkg.sv
hw/hello_pkg.sv
hw/axi_skid_buffer.sv
hw/pcis_slave_bridge.sv
hw/hello_regs.sv
hw/cl_hello_world.sv
dv/cl_hello_world_props.sv
dv/tb_cl_hello_world.sv
